// ==== include/trig_defines.svh ====
// trigger constants
`ifndef TRIG_DEFINES_SVH
`define TRIG_DEFINES_SVH

`define TRIG_NUM_SAMPLES 40   // samples per clklvds cycle from the adc
`define TRIG_SAMPLE_W    12   // signed adc sample
`define TRIG_ADDR_W      10   // ram write address
`define TRIG_LEN_W       16   // pre and post acquisition length
`define TRIG_TOT_W       8    // time over threshold
`define TRIG_DS_W        5    // downsample exponent
`define TRIG_STATE_W     8    // acqstate as read back by software
`define TRIG_MODE_W      3

// acquisition states, codes kept for software compatibility
`define TRIG_ST_IDLE      8'd0
`define TRIG_ST_ARM       8'd1    // edge trigger, first step
`define TRIG_ST_FIRE      8'd2    // edge trigger, second step
`define TRIG_ST_LVDS_WAIT 8'd5
`define TRIG_ST_FORCE     8'd6
`define TRIG_ST_EXT_WAIT  8'd7
`define TRIG_ST_PRE       8'd200
`define TRIG_ST_POST      8'd250
`define TRIG_ST_READY     8'd251

// trigger modes
`define TRIG_MODE_OFF   3'd0
`define TRIG_MODE_RISE  3'd1
`define TRIG_MODE_FALL  3'd2
`define TRIG_MODE_LVDS  3'd3
`define TRIG_MODE_FORCE 3'd4
`define TRIG_MODE_EXT   3'd5

`endif

// ==== rtl/acq_sequencer.sv ====
// acquisition sequencer
`default_nettype none
`include "trig_defines.svh"

module acq_sequencer (
   input  logic                     clklvds,
   input  logic                     rst_n,
   input  trig_pkg::sample_t        samples [`TRIG_NUM_SAMPLES],
   input  logic                     didreadout,
   trig_cfg_if.seq                  cfg,
   acq_ctrl_if.seq                  ctl,
   output logic [`TRIG_STATE_W-1:0] acqstate,
   output logic                     lvds_out,
   output logic                     lvds_out_b,
   output logic                     auxout
);

   trig_pkg::acq_state_t   state;
   trig_pkg::trig_mode_t   active_mode;   // mode latched in idle
   logic [`TRIG_LEN_W-1:0] len_cnt;       // pre and post tick count
   logic [`TRIG_TOT_W-1:0] tot_cnt;
   logic                   any_below, any_above;
   logic                   didreadout_r;
   logic                   ext_armed;     // ext level high since its edge
   logic                   resend_fwd, resend_bwd;
   logic                   fire_d;        // first post cycle
   logic                   mode_changed, rising, step1, step2;
   logic                   fwd_hit, bwd_hit;
   logic                   leaving;       // last cycle before idle or ready

   sample_threshold_compare u_cmp (
      .samples      (samples),
      .lower_thresh (cfg.lower_thresh),
      .upper_thresh (cfg.upper_thresh),
      .any_below    (any_below),
      .any_above    (any_above)
   );

   assign mode_changed = active_mode != cfg.mode;
   assign rising       = active_mode == trig_pkg::MODE_RISE;
   assign step1        = rising ? any_below : any_above;   // falling is the mirror
   assign step2        = rising ? any_above : any_below;
   assign fwd_hit      = cfg.lvds_in && !cfg.first_board;    // ignored on first board
   assign bwd_hit      = cfg.lvds_in_b && !cfg.last_board;   // ignored on last board

   always_comb begin
      ctl.fire = 1'b0;
      case (state)
         trig_pkg::ST_FIRE:      ctl.fire = !mode_changed && step2 && tot_cnt >= cfg.tot;
         trig_pkg::ST_LVDS_WAIT: ctl.fire = !mode_changed && (fwd_hit || bwd_hit);
         trig_pkg::ST_EXT_WAIT:  ctl.fire = !mode_changed && ext_armed && cfg.ext_level &&
                                            tot_cnt >= cfg.tot;
         trig_pkg::ST_FORCE:     ctl.fire = 1'b1;   // unconditional
         default:                ctl.fire = 1'b0;
      endcase
   end

   assign ctl.done       = state == trig_pkg::ST_POST && len_cnt >= cfg.post_len;
   // no tick in the last cycle, so no write lands in idle or ready
   assign leaving        = ctl.done ||
                           (mode_changed && state inside {trig_pkg::ST_PRE, trig_pkg::ST_ARM,
                            trig_pkg::ST_FIRE, trig_pkg::ST_LVDS_WAIT, trig_pkg::ST_EXT_WAIT});
   assign ctl.capture_en = state != trig_pkg::ST_IDLE && state != trig_pkg::ST_READY &&
                           !leaving;
   assign ctl.ext_ofs    = state == trig_pkg::ST_EXT_WAIT;   // input path delay of 3
   assign acqstate       = state;
   assign auxout         = state == trig_pkg::ST_POST;       // back panel trigger out

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         state        <= trig_pkg::ST_IDLE;
         active_mode  <= trig_pkg::MODE_OFF;
         len_cnt      <= '0;
         tot_cnt      <= '0;
         ext_armed    <= 1'b0;
         resend_fwd   <= 1'b0;
         resend_bwd   <= 1'b0;
         didreadout_r <= 1'b0;
      end else begin
         didreadout_r <= didreadout;
         case (state)
            trig_pkg::ST_IDLE: begin
               active_mode <= cfg.mode;
               len_cnt     <= '0;
               tot_cnt     <= '0;
               ext_armed   <= 1'b0;
               resend_fwd  <= 1'b1;   // both sides unless lvds says otherwise
               resend_bwd  <= 1'b1;
               if (cfg.mode != trig_pkg::MODE_OFF && cfg.live) state <= trig_pkg::ST_PRE;
            end
            trig_pkg::ST_PRE: begin
               if (mode_changed) state <= trig_pkg::ST_IDLE;
               else if (len_cnt < cfg.pre_len) begin
                  if (ctl.tick) len_cnt <= len_cnt + 1'b1;
               end else begin
                  len_cnt <= '0;   // reused for post
                  case (active_mode)
                     trig_pkg::MODE_RISE,
                     trig_pkg::MODE_FALL:  state <= trig_pkg::ST_ARM;
                     trig_pkg::MODE_LVDS:  state <= trig_pkg::ST_LVDS_WAIT;
                     trig_pkg::MODE_FORCE: state <= trig_pkg::ST_FORCE;
                     trig_pkg::MODE_EXT:   state <= trig_pkg::ST_EXT_WAIT;
                     default:              state <= trig_pkg::ST_IDLE;
                  endcase
               end
            end
            trig_pkg::ST_ARM: begin
               if (mode_changed) state <= trig_pkg::ST_IDLE;
               else if (step1) state <= trig_pkg::ST_FIRE;
            end
            trig_pkg::ST_FIRE: begin
               if (mode_changed) state <= trig_pkg::ST_IDLE;
               else if (ctl.fire) state <= trig_pkg::ST_POST;
               else if (step2 && ctl.tick) tot_cnt <= tot_cnt + 1'b1;   // time over threshold
            end
            trig_pkg::ST_LVDS_WAIT: begin
               if (mode_changed) state <= trig_pkg::ST_IDLE;
               else if (ctl.fire) begin
                  resend_fwd <= !bwd_hit;   // keep passing on away from the source
                  resend_bwd <= bwd_hit;
                  state      <= trig_pkg::ST_POST;
               end
            end
            trig_pkg::ST_FORCE: state <= trig_pkg::ST_POST;
            trig_pkg::ST_EXT_WAIT: begin
               if (mode_changed) state <= trig_pkg::ST_IDLE;
               else if (ctl.fire) state <= trig_pkg::ST_POST;
               else begin
                  ext_armed <= cfg.ext_rise || (ext_armed && cfg.ext_level);
                  tot_cnt   <= (ext_armed && cfg.ext_level) ? tot_cnt + 1'b1 : '0;
               end
            end
            trig_pkg::ST_POST: begin
               if (ctl.done) state <= trig_pkg::ST_READY;
               else if (ctl.tick) len_cnt <= len_cnt + 1'b1;
            end
            trig_pkg::ST_READY: begin
               if (didreadout_r) state <= trig_pkg::ST_IDLE;   // wait for readout
            end
            default: state <= trig_pkg::ST_IDLE;
         endcase
      end
   end

   // lvds chain, repeat inputs plus the trigger pulses
   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         fire_d     <= 1'b0;
         lvds_out   <= 1'b0;
         lvds_out_b <= 1'b0;
      end else begin
         fire_d     <= ctl.fire;
         lvds_out   <= fwd_hit || ctl.fire || (fire_d && resend_fwd);
         lvds_out_b <= bwd_hit || ctl.fire || (fire_d && resend_bwd);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/ram_write_ctrl.sv ====
// ram write control
`default_nettype none
`include "trig_defines.svh"

module ram_write_ctrl (
   input  logic                    clklvds,
   input  logic                    rst_n,
   trig_cfg_if.ram                 cfg,
   acq_ctrl_if.ram                 ctl,
   output logic                    ram_wr,
   output logic [`TRIG_ADDR_W-1:0] ram_wr_address,
   output logic [`TRIG_ADDR_W-1:0] ram_address_triggered,
   output logic [31:0]             eventcounter
);

   logic [(1 << `TRIG_DS_W)-1:0] ds_cnt;    // tick when bit downsample is set
   logic [`TRIG_ADDR_W-1:0]      trig_addr;

   assign ctl.tick = ctl.capture_en && ds_cnt[cfg.downsample];

   // address of the trigger, tot samples back, ext input lags by 3
   assign trig_addr = ram_wr_address - `TRIG_ADDR_W'(cfg.tot) +
                      (ctl.ext_ofs ? `TRIG_ADDR_W'(3) : `TRIG_ADDR_W'(0));

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         ds_cnt                <= 1;
         ram_wr                <= 1'b0;
         ram_wr_address        <= '0;
         ram_address_triggered <= '0;
         eventcounter          <= '0;
      end else begin
         if (!ctl.capture_en || ctl.tick) ds_cnt <= 1;   // reload
         else ds_cnt <= ds_cnt + 1'b1;
         ram_wr <= ctl.tick;
         if (ctl.tick) ram_wr_address <= ram_wr_address + 1'b1;   // wraps around the ram
         if (ctl.fire) ram_address_triggered <= trig_addr;
         if (ctl.done) eventcounter <= eventcounter + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/sample_threshold_compare.sv ====
// sample threshold compare
`default_nettype none
`include "trig_defines.svh"

module sample_threshold_compare (
   input  trig_pkg::sample_t samples [`TRIG_NUM_SAMPLES],
   input  trig_pkg::sample_t lower_thresh,
   input  trig_pkg::sample_t upper_thresh,
   output logic              any_below,
   output logic              any_above
);

   // all samples of the cycle, signed compares
   always_comb begin
      any_below = 1'b0;
      any_above = 1'b0;
      for (int i = 0; i < `TRIG_NUM_SAMPLES; i++) begin
         if (samples[i] < lower_thresh) any_below = 1'b1;
         if (samples[i] > upper_thresh) any_above = 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/trig_config_decode.sv ====
// trigger configuration decode
`default_nettype none
`include "trig_defines.svh"

module trig_config_decode (
   input  logic                   clklvds,
   input  logic                   rst_n,
   input  logic [7:0]             triggertype,
   input  trig_pkg::sample_t      lowerthresh,
   input  trig_pkg::sample_t      upperthresh,
   input  logic [`TRIG_LEN_W-1:0] prelengthtotake,
   input  logic [`TRIG_LEN_W-1:0] lengthtotake,
   input  logic [`TRIG_TOT_W-1:0] triggertot,
   input  logic [`TRIG_DS_W-1:0]  downsample,
   input  logic [1:0]             firstlast,     // 1 first board, 2 last board
   input  logic                   triggerlive,
   input  logic                   lvdsin_trig,
   input  logic                   lvdsin_trig_b,
   input  logic                   exttrigin,
   trig_cfg_if.src                cfg
);

   logic ext_prev;   // ext_level one cycle back

   always_ff @(posedge clklvds or negedge rst_n) begin
      if (!rst_n) begin
         cfg.mode         <= trig_pkg::MODE_OFF;
         cfg.lower_thresh <= '0;
         cfg.upper_thresh <= '0;
         cfg.pre_len      <= '0;
         cfg.post_len     <= '0;
         cfg.tot          <= '0;
         cfg.downsample   <= '0;
         cfg.first_board  <= 1'b0;
         cfg.last_board   <= 1'b0;
         cfg.live         <= 1'b0;
         cfg.lvds_in      <= 1'b0;
         cfg.lvds_in_b    <= 1'b0;
         cfg.ext_level    <= 1'b0;
         cfg.ext_rise     <= 1'b0;
         ext_prev         <= 1'b0;
      end else begin
         case (triggertype)
            8'd1:    cfg.mode <= trig_pkg::MODE_RISE;
            8'd2:    cfg.mode <= trig_pkg::MODE_FALL;
            8'd3:    cfg.mode <= trig_pkg::MODE_LVDS;
            8'd4:    cfg.mode <= trig_pkg::MODE_FORCE;
            8'd5:    cfg.mode <= trig_pkg::MODE_EXT;
            default: cfg.mode <= trig_pkg::MODE_OFF;   // rolling, echo etc not supported
         endcase
         cfg.lower_thresh <= lowerthresh;
         cfg.upper_thresh <= upperthresh;
         cfg.pre_len      <= prelengthtotake;
         cfg.post_len     <= lengthtotake;
         cfg.tot          <= triggertot;
         cfg.downsample   <= downsample;
         cfg.first_board  <= firstlast[0];
         cfg.last_board   <= firstlast[1];
         cfg.live         <= triggerlive;
         cfg.lvds_in      <= lvdsin_trig;
         cfg.lvds_in_b    <= lvdsin_trig_b;
         cfg.ext_level    <= exttrigin;                     // back panel sma
         ext_prev         <= cfg.ext_level;
         cfg.ext_rise     <= cfg.ext_level && !ext_prev;    // rising edge marker
      end
   end

endmodule

`default_nettype wire

// ==== rtl/trig_if.sv ====
// trigger internal interfaces
`default_nettype none
`include "trig_defines.svh"

// registered configuration and external inputs
interface trig_cfg_if;
   trig_pkg::trig_mode_t      mode;
   trig_pkg::sample_t         lower_thresh;
   trig_pkg::sample_t         upper_thresh;
   logic [`TRIG_LEN_W-1:0]    pre_len;
   logic [`TRIG_LEN_W-1:0]    post_len;
   logic [`TRIG_TOT_W-1:0]    tot;
   logic [`TRIG_DS_W-1:0]     downsample;
   logic                      first_board;
   logic                      last_board;
   logic                      live;          // triggerlive, registered
   logic                      lvds_in;
   logic                      lvds_in_b;
   logic                      ext_level;
   logic                      ext_rise;      // one cycle after ext_level rises

   modport src (output mode, lower_thresh, upper_thresh, pre_len, post_len, tot,
                downsample, first_board, last_board, live, lvds_in, lvds_in_b,
                ext_level, ext_rise);
   modport seq (input mode, lower_thresh, upper_thresh, pre_len, post_len, tot,
                first_board, last_board, live, lvds_in, lvds_in_b, ext_level, ext_rise);
   modport ram (input tot, downsample);
endinterface

// sequencer to ram writer, plain strobes and levels
interface acq_ctrl_if;
   logic tick;         // downsampled sample strobe
   logic capture_en;   // level, writing allowed
   logic fire;         // one cycle, trigger accepted
   logic ext_ofs;      // fire came from the back panel input
   logic done;         // one cycle, post acquisition complete

   modport ram (output tick, input capture_en, fire, ext_ofs, done);
   modport seq (input tick, output capture_en, fire, ext_ofs, done);
endinterface

`default_nettype wire

// ==== rtl/trig_pkg.sv ====
// trigger types
`default_nettype none
`include "trig_defines.svh"

package trig_pkg;

   typedef logic signed [`TRIG_SAMPLE_W-1:0] sample_t;

   typedef enum logic [`TRIG_STATE_W-1:0] {
      ST_IDLE      = `TRIG_ST_IDLE,
      ST_ARM       = `TRIG_ST_ARM,
      ST_FIRE      = `TRIG_ST_FIRE,
      ST_LVDS_WAIT = `TRIG_ST_LVDS_WAIT,
      ST_FORCE     = `TRIG_ST_FORCE,
      ST_EXT_WAIT  = `TRIG_ST_EXT_WAIT,
      ST_PRE       = `TRIG_ST_PRE,
      ST_POST      = `TRIG_ST_POST,
      ST_READY     = `TRIG_ST_READY
   } acq_state_t;

   typedef enum logic [`TRIG_MODE_W-1:0] {
      MODE_OFF   = `TRIG_MODE_OFF,     // also any unsupported trigger type
      MODE_RISE  = `TRIG_MODE_RISE,
      MODE_FALL  = `TRIG_MODE_FALL,
      MODE_LVDS  = `TRIG_MODE_LVDS,    // trigger from a neighbour board
      MODE_FORCE = `TRIG_MODE_FORCE,   // auto trigger
      MODE_EXT   = `TRIG_MODE_EXT      // back panel input
   } trig_mode_t;

endpackage

`default_nettype wire

// ==== rtl/trigger_top.sv ====
// acquisition trigger top
`default_nettype none
`include "trig_defines.svh"

module trigger_top (
   input  logic                     clklvds,
   input  logic                     rst_n,
   input  trig_pkg::sample_t        samples [`TRIG_NUM_SAMPLES],
   input  logic [7:0]               triggertype,
   input  trig_pkg::sample_t        lowerthresh,
   input  trig_pkg::sample_t        upperthresh,
   input  logic [`TRIG_LEN_W-1:0]   prelengthtotake,
   input  logic [`TRIG_LEN_W-1:0]   lengthtotake,
   input  logic [`TRIG_TOT_W-1:0]   triggertot,
   input  logic [`TRIG_DS_W-1:0]    downsample,
   input  logic [1:0]               firstlast,
   input  logic                     triggerlive,
   input  logic                     didreadout,
   input  logic                     lvdsin_trig,
   input  logic                     lvdsin_trig_b,
   input  logic                     exttrigin,
   output logic                     lvdsout_trig,
   output logic                     lvdsout_trig_b,
   output logic                     auxout,
   output logic                     ram_wr,
   output logic [`TRIG_ADDR_W-1:0]  ram_wr_address,
   output logic [`TRIG_ADDR_W-1:0]  ram_address_triggered,
   output logic [31:0]              eventcounter,
   output logic [`TRIG_STATE_W-1:0] acqstate
);

   trig_cfg_if cfg_if ();
   acq_ctrl_if ctl_if ();

   trig_config_decode u_decode (
      .clklvds         (clklvds),
      .rst_n           (rst_n),
      .triggertype     (triggertype),
      .lowerthresh     (lowerthresh),
      .upperthresh     (upperthresh),
      .prelengthtotake (prelengthtotake),
      .lengthtotake    (lengthtotake),
      .triggertot      (triggertot),
      .downsample      (downsample),
      .firstlast       (firstlast),
      .triggerlive     (triggerlive),
      .lvdsin_trig     (lvdsin_trig),
      .lvdsin_trig_b   (lvdsin_trig_b),
      .exttrigin       (exttrigin),
      .cfg             (cfg_if.src)
   );

   acq_sequencer u_seq (
      .clklvds    (clklvds),
      .rst_n      (rst_n),
      .samples    (samples),
      .didreadout (didreadout),
      .cfg        (cfg_if.seq),
      .ctl        (ctl_if.seq),
      .acqstate   (acqstate),
      .lvds_out   (lvdsout_trig),
      .lvds_out_b (lvdsout_trig_b),
      .auxout     (auxout)
   );

   ram_write_ctrl u_ram (
      .clklvds               (clklvds),
      .rst_n                 (rst_n),
      .cfg                   (cfg_if.ram),
      .ctl                   (ctl_if.ram),
      .ram_wr                (ram_wr),
      .ram_wr_address        (ram_wr_address),
      .ram_address_triggered (ram_address_triggered),
      .eventcounter          (eventcounter)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the trigger testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module trigger_tb -o trigger_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/trigger_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "Checks failed" "$log"; then
   exit 1
fi
exit 0

// ==== tb.f ====
+incdir+include
rtl/trig_pkg.sv
rtl/trig_if.sv
rtl/trig_config_decode.sv
rtl/sample_threshold_compare.sv
rtl/acq_sequencer.sv
rtl/ram_write_ctrl.sv
rtl/trigger_top.sv
verification/trigger_checker.sv
verification/trigger_tb.sv

// ==== verification/trigger_checker.sv ====
// trigger port assertions
`default_nettype none
`include "trig_defines.svh"

module trigger_checker (
   input logic                     clklvds,
   input logic                     rst_n,
   input logic [`TRIG_STATE_W-1:0] acqstate,
   input logic                     ram_wr,
   input logic                     auxout
);

   logic parked;   // idle or waiting for readout
   assign parked = acqstate == `TRIG_ST_IDLE || acqstate == `TRIG_ST_READY;

   a_no_write_parked: assert property (@(posedge clklvds) disable iff (!rst_n)
      parked |-> !ram_wr)
      else $error("ram_wr high while acquisition is parked");

   a_legal_state: assert property (@(posedge clklvds) disable iff (!rst_n)
      acqstate inside {`TRIG_ST_IDLE, `TRIG_ST_ARM, `TRIG_ST_FIRE, `TRIG_ST_LVDS_WAIT,
                       `TRIG_ST_FORCE, `TRIG_ST_EXT_WAIT, `TRIG_ST_PRE, `TRIG_ST_POST,
                       `TRIG_ST_READY})
      else $error("acqstate holds an unknown code %0d", acqstate);

   a_aux_in_post: assert property (@(posedge clklvds) disable iff (!rst_n)
      auxout == (acqstate == `TRIG_ST_POST))   // trigger out marks post acquisition
      else $error("auxout does not follow the post state");

endmodule

bind trigger_top trigger_checker u_checker (
   .clklvds  (clklvds),
   .rst_n    (rst_n),
   .acqstate (acqstate),
   .ram_wr   (ram_wr),
   .auxout   (auxout)
);

`default_nettype wire

// ==== verification/trigger_tb.sv ====
// acquisition trigger testbench
`default_nettype none
`include "trig_defines.svh"

module trigger_tb;

   localparam logic [2:0] P_FORCE = 3'd0;   // sample pattern selectors
   localparam logic [2:0] P_RISE  = 3'd1;
   localparam logic [2:0] P_FALL  = 3'd2;
   localparam logic [2:0] P_STUCK = 3'd3;   // stays between the thresholds
   localparam logic [2:0] P_LVDS  = 3'd4;
   localparam logic [2:0] P_EXT   = 3'd5;
   localparam int         NUM_ROWS = 7;

   typedef struct packed {
      logic [7:0]                ttype;
      logic [`TRIG_SAMPLE_W-1:0] lower;
      logic [`TRIG_SAMPLE_W-1:0] upper;
      logic [`TRIG_LEN_W-1:0]    pre;
      logic [`TRIG_LEN_W-1:0]    post;
      logic [`TRIG_TOT_W-1:0]    tot;
      logic [1:0]                ds_max;      // random exponent up to this
      logic [1:0]                firstlast;
      logic [2:0]                pattern;
      logic [`TRIG_STATE_W-1:0]  exp_state;
   } row_t;

   logic                     clklvds;
   logic                     rst_n;
   trig_pkg::sample_t        samples [`TRIG_NUM_SAMPLES];
   logic [7:0]               triggertype;
   trig_pkg::sample_t        lowerthresh, upperthresh;
   logic [`TRIG_LEN_W-1:0]   prelengthtotake, lengthtotake;
   logic [`TRIG_TOT_W-1:0]   triggertot;
   logic [`TRIG_DS_W-1:0]    downsample;
   logic [1:0]               firstlast;
   logic                     triggerlive, didreadout, lvdsin_trig, lvdsin_trig_b, exttrigin;
   logic                     lvdsout_trig, lvdsout_trig_b, auxout, ram_wr;
   logic [`TRIG_ADDR_W-1:0]  ram_wr_address, ram_address_triggered;
   logic [31:0]              eventcounter;
   logic [`TRIG_STATE_W-1:0] acqstate;

   row_t                     rows [NUM_ROWS];
   integer                   seed;
   int                       errors = 0;
   int                       checks = 0;
   int                       cycles = 0;      // clock cycles since time zero
   int                       limit = 0;
   int                       events = 0;      // expected eventcounter
   int                       cur_ds = 0;
   int                       cur_tot = 0;
   logic                     cur_ext = 1'b0;  // row fires from the back panel
   int                       last_wr = -1;    // cycle of the previous ram_wr or -1
   int                       post_wr = 0;     // writes counted inside post
   int                       prev_addr = 0;
   logic [`TRIG_STATE_W-1:0] prev_state = '0;

   trigger_top UUT (.*);   // tb signals carry the port names

   initial begin
      clklvds = 1'b0;
      forever #5 clklvds = ~clklvds;
   end

   always @(posedge clklvds) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout: run did not finish in %0d cycles, acqstate %0d", limit, acqstate);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic compare_value(input string name, input int got, input int exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got %0h expected %0h", name, got, exp);
      end
   endtask

   // write spacing, post write count and triggered address
   always @(negedge clklvds) begin
      if (rst_n) begin
         if (ram_wr && last_wr >= 0) compare_value("ram_wr spacing", cycles - last_wr, 1 << cur_ds);
         if (ram_wr) last_wr = cycles;
         if (acqstate == `TRIG_ST_IDLE || acqstate == `TRIG_ST_READY) last_wr = -1;
         if (acqstate == `TRIG_ST_POST && prev_state != `TRIG_ST_POST) begin
            post_wr = 0;   // write in this cycle belongs to the fire cycle
            compare_value("ram_address_triggered", ram_address_triggered,
                          (prev_addr - cur_tot + (cur_ext ? 3 : 0)) & ((1 << `TRIG_ADDR_W) - 1));
         end else if (acqstate == `TRIG_ST_POST && ram_wr) post_wr++;
         prev_state = acqstate;
         prev_addr  = ram_wr_address;
      end
   end

   task automatic wait_state(input logic [`TRIG_STATE_W-1:0] st);
      @(negedge clklvds);
      while (acqstate !== st) @(negedge clklvds);   // bounded by the cycle limit
   endtask

   // kind 0 between thresholds, 1 below lower, 2 above upper
   task automatic fill_samples(input int kind, input int lo, input int hi);
      int i;
      int r;
      for (i = 0; i < `TRIG_NUM_SAMPLES; i++) begin
         r = $unsigned($random(seed)) % 64;
         case (kind)
            0:       samples[i] <= trig_pkg::sample_t'(lo + 1 + r % (hi - lo - 1));
            1:       samples[i] <= trig_pkg::sample_t'(lo - 1 - r);
            default: samples[i] <= trig_pkg::sample_t'(hi + 1 + r);
         endcase
      end
   endtask

   task automatic run_row(input row_t r);
      int ds;
      int lo;
      int hi;
      int seen;
      ds      = $unsigned($random(seed)) % (r.ds_max + 1);
      lo      = $signed(r.lower);
      hi      = $signed(r.upper);
      cur_ds  = ds;
      cur_tot = r.tot;
      cur_ext = r.pattern == P_EXT;   // ext input adds its path delay of 3
      @(posedge clklvds);
      triggertype     <= r.ttype;
      lowerthresh     <= r.lower;
      upperthresh     <= r.upper;
      prelengthtotake <= r.pre;
      lengthtotake    <= r.post;
      triggertot      <= r.tot;
      downsample      <= `TRIG_DS_W'(ds);
      firstlast       <= r.firstlast;
      fill_samples(0, lo, hi);
      repeat (3) @(posedge clklvds);
      if (r.pattern == P_LVDS) begin   // forwarding checked while idle
         @(posedge clklvds) lvdsin_trig <= 1'b1;
         @(posedge clklvds) lvdsin_trig <= 1'b0;
         seen = 0;
         repeat (4) begin
            @(negedge clklvds);
            if (lvdsout_trig) seen++;
         end
         compare_value("lvdsout_trig pulses", seen, r.firstlast[0] ? 0 : 1);
      end
      @(posedge clklvds) triggerlive <= 1'b1;
      case (r.pattern)
         P_RISE, P_FALL: begin
            wait_state(`TRIG_ST_ARM);
            @(posedge clklvds) fill_samples(r.pattern == P_RISE ? 1 : 2, lo, hi);
            wait_state(`TRIG_ST_FIRE);
            @(posedge clklvds) fill_samples(r.pattern == P_RISE ? 2 : 1, lo, hi);
         end
         P_STUCK: begin
            wait_state(`TRIG_ST_ARM);
            repeat (30) @(negedge clklvds);
         end
         P_LVDS: begin
            wait_state(`TRIG_ST_LVDS_WAIT);
            if (r.firstlast[0]) begin   // first board ignores the forward input
               @(posedge clklvds) lvdsin_trig <= 1'b1;
               repeat (3) @(posedge clklvds);
               lvdsin_trig <= 1'b0;
               repeat (3) @(negedge clklvds);
               compare_value("acqstate", acqstate, `TRIG_ST_LVDS_WAIT);
            end
            @(posedge clklvds) lvdsin_trig_b <= 1'b1;
            @(posedge clklvds) lvdsin_trig_b <= 1'b0;
         end
         P_EXT: begin
            wait_state(`TRIG_ST_EXT_WAIT);
            @(posedge clklvds) exttrigin <= 1'b1;
            repeat (r.tot - 2) @(posedge clklvds);
            exttrigin <= 1'b0;   // too short to fire
            repeat (12) @(negedge clklvds);
            compare_value("acqstate", acqstate, `TRIG_ST_EXT_WAIT);
            @(posedge clklvds) exttrigin <= 1'b1;
         end
         default: ;   // forced trigger needs no stimulus
      endcase
      if (r.exp_state == `TRIG_ST_READY) begin
         wait_state(`TRIG_ST_READY);
         events++;
         compare_value("eventcounter", eventcounter, events);
         compare_value("ram_wr in post", post_wr, r.post);
      end else begin
         compare_value("acqstate", acqstate, r.exp_state);
      end
      @(posedge clklvds);
      triggerlive <= 1'b0;
      exttrigin   <= 1'b0;
      if (r.exp_state == `TRIG_ST_READY) didreadout <= 1'b1;
      else triggertype <= 8'd0;   // mode change drops the wait
      @(posedge clklvds) didreadout <= 1'b0;
      wait_state(`TRIG_ST_IDLE);
   endtask

   initial begin
      int i;
      seed = 85174;
      // type, lower, upper, pre, post, tot, ds_max, firstlast, pattern, final state
      rows[0] = '{8'd4, -12'sd100, 12'sd100, 16'd5, 16'd12, 8'd2, 2'd3, 2'd0, P_FORCE,
                  `TRIG_ST_READY};
      rows[1] = '{8'd1, -12'sd200, 12'sd300, 16'd4, 16'd10, 8'd3, 2'd3, 2'd0, P_RISE,
                  `TRIG_ST_READY};
      rows[2] = '{8'd2, -12'sd150, 12'sd250, 16'd3, 16'd8, 8'd2, 2'd2, 2'd0, P_FALL,
                  `TRIG_ST_READY};
      rows[3] = '{8'd1, -12'sd300, 12'sd300, 16'd2, 16'd6, 8'd1, 2'd1, 2'd0, P_STUCK,
                  `TRIG_ST_ARM};
      rows[4] = '{8'd3, -12'sd100, 12'sd100, 16'd3, 16'd7, 8'd0, 2'd3, 2'd1, P_LVDS,
                  `TRIG_ST_READY};
      rows[5] = '{8'd3, -12'sd100, 12'sd100, 16'd2, 16'd5, 8'd1, 2'd2, 2'd0, P_LVDS,
                  `TRIG_ST_READY};
      rows[6] = '{8'd5, -12'sd100, 12'sd100, 16'd3, 16'd9, 8'd6, 2'd3, 2'd0, P_EXT,
                  `TRIG_ST_READY};
      for (i = 0; i < NUM_ROWS; i++)
         limit += (rows[i].pre + rows[i].post + 20) * (1 << rows[i].ds_max) + 100;
      rst_n = 1'b0;
      {triggertype, prelengthtotake, lengthtotake, triggertot, downsample, firstlast} = '0;
      {lowerthresh, upperthresh} = '0;
      {triggerlive, didreadout, lvdsin_trig, lvdsin_trig_b, exttrigin} = '0;
      for (i = 0; i < `TRIG_NUM_SAMPLES; i++) samples[i] = '0;
      repeat (2) @(posedge clklvds);
      rst_n <= 1'b1;
      @(negedge clklvds);
      compare_value("acqstate", acqstate, `TRIG_ST_IDLE);
      compare_value("ram_wr", ram_wr, 0);
      compare_value("lvdsout_trig", lvdsout_trig, 0);
      compare_value("lvdsout_trig_b", lvdsout_trig_b, 0);
      compare_value("auxout", auxout, 0);
      compare_value("ram_wr_address", ram_wr_address, 0);
      compare_value("ram_address_triggered", ram_address_triggered, 0);
      compare_value("eventcounter", eventcounter, 0);
      for (i = 0; i < NUM_ROWS; i++) run_row(rows[i]);
      $display("%0d checks run, %0d errors", checks, errors);
      if (errors == 0) $display("All checks passed");
      else $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
